// ==== rtl/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  // Major opcodes, bits [6:0] of the instruction word
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // Instruction class, steers execute and writeback
  typedef enum logic [3:0] {
    OP,       // Register-register ALU
    OP_IMM,   // Register-immediate ALU
    LUI,
    LOAD,     // LW only
    STORE,    // SW only
    BRANCH,
    JAL,
    ILLEGAL   // Retires as a no-op
  } inst_type_e;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,   // Signed compare
    SLL,
    SRL,
    SRA
  } alu_op_e;

  typedef enum logic [1:0] {
    EQ,
    NE,
    LT,  // Signed
    GE   // Signed
  } br_op_e;

  // Everything execute and writeback need from one instruction
  typedef struct packed {
    inst_type_e  itype;
    alu_op_e     alu_op;
    br_op_e      br_op;
    logic [31:0] imm;     // Already sign-extended
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
  } decoded_t;

endpackage

`default_nettype wire

// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

  // Memory sizes in 32-bit words
  localparam int IMEM_DEPTH = 128;
  localparam int DMEM_DEPTH = 1024;
  localparam int IMEM_AW    = $clog2(IMEM_DEPTH);  // Word address bits
  localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

  // One instruction walks FETCH through WRITEBACK, five cycles
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    DECODE,
    EXECUTE,
    MEMORY,
    WRITEBACK
  } core_state_e;

  typedef struct packed {
    logic [31:0] result;      // ALU, LUI or link value
    logic [31:0] mem_addr;    // Byte address, rs1 + imm
    logic [31:0] store_data;
    logic [31:0] next_pc;
  } exec_result_t;

  // Retire trace of one finished instruction
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic        wen;
  } retire_t;

endpackage

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
  input  wire                          clk_100mhz,
  input  wire                          rst_in,
  input  wire                          run,
  input  wire                          prog_we,
  input  wire [core_pkg::IMEM_AW-1:0]  prog_addr,
  input  wire [31:0]                   prog_data,
  input  wire [31:0]                   next_pc,
  output core_pkg::core_state_e        state,
  output logic [31:0]                  pc,
  output logic [31:0]                  inst
);

  logic [31:0] imem [0:core_pkg::IMEM_DEPTH-1];  // Program memory, no reset
  logic [core_pkg::IMEM_AW-1:0] pc_word;
  logic load_en;

  assign pc_word = pc[core_pkg::IMEM_AW+1:2];  // Byte pc to word index
  // Loading only while stopped
  assign load_en = prog_we && !run && (state == core_pkg::IDLE);

  always_ff @(posedge clk_100mhz) begin
    if (load_en) imem[prog_addr] <= prog_data;
    if (state == core_pkg::FETCH) inst <= imem[pc_word];  // Held until next FETCH
  end

  // Sequencer and pc
  always_ff @(posedge clk_100mhz) begin
    if (rst_in) begin
      state <= core_pkg::IDLE;
      pc    <= 32'h0;
    end else begin
      case (state)
        core_pkg::IDLE: begin
          pc <= 32'h0;  // Every run starts at address 0
          if (run) state <= core_pkg::FETCH;
        end
        core_pkg::FETCH:   state <= core_pkg::DECODE;
        core_pkg::DECODE:  state <= core_pkg::EXECUTE;
        core_pkg::EXECUTE: state <= core_pkg::MEMORY;
        core_pkg::MEMORY:  state <= core_pkg::WRITEBACK;
        core_pkg::WRITEBACK: begin
          pc <= next_pc;  // Execute output still valid here
          // Run low lets this instruction finish, then stop
          state <= run ? core_pkg::FETCH : core_pkg::IDLE;
        end
        default: state <= core_pkg::IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module decoder (
  input  wire [31:0]          inst,
  output rv_isa_pkg::decoded_t dec
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // Immediates, sign from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec        = '0;
    dec.itype  = rv_isa_pkg::ILLEGAL;  // Until proven otherwise
    dec.alu_op = rv_isa_pkg::ADD;      // Address adds for load and store
    dec.br_op  = rv_isa_pkg::EQ;
    dec.rs1    = inst[19:15];
    dec.rs2    = inst[24:20];
    dec.rd     = inst[11:7];
    case (opcode)
      rv_isa_pkg::OPC_OP: begin
        dec.itype = rv_isa_pkg::OP;
        case (funct3)
          3'b000: dec.alu_op = funct7[5] ? rv_isa_pkg::SUB : rv_isa_pkg::ADD;
          3'b111: dec.alu_op = rv_isa_pkg::AND;
          3'b110: dec.alu_op = rv_isa_pkg::OR;
          3'b100: dec.alu_op = rv_isa_pkg::XOR;
          3'b010: dec.alu_op = rv_isa_pkg::SLT;
          3'b001: dec.alu_op = rv_isa_pkg::SLL;
          3'b101: dec.alu_op = funct7[5] ? rv_isa_pkg::SRA : rv_isa_pkg::SRL;
          default: dec.itype = rv_isa_pkg::ILLEGAL;  // SLTU not supported
        endcase
        // Only funct7 of 0 or 0x20 exists, and 0x20 only on ADD/SUB and shifts
        if (funct7 != 7'h00 && !(funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)))
          dec.itype = rv_isa_pkg::ILLEGAL;
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        dec.itype = rv_isa_pkg::OP_IMM;
        dec.imm   = imm_i;
        case (funct3)
          3'b000: dec.alu_op = rv_isa_pkg::ADD;
          3'b111: dec.alu_op = rv_isa_pkg::AND;
          3'b110: dec.alu_op = rv_isa_pkg::OR;
          3'b100: dec.alu_op = rv_isa_pkg::XOR;
          3'b010: dec.alu_op = rv_isa_pkg::SLT;
          default: dec.itype = rv_isa_pkg::ILLEGAL;  // No immediate shifts
        endcase
      end
      rv_isa_pkg::OPC_LUI: begin
        dec.itype = rv_isa_pkg::LUI;
        dec.imm   = imm_u;
      end
      rv_isa_pkg::OPC_LOAD: begin
        dec.imm = imm_i;
        if (funct3 == 3'b010) dec.itype = rv_isa_pkg::LOAD;  // Word only
      end
      rv_isa_pkg::OPC_STORE: begin
        dec.imm = imm_s;
        if (funct3 == 3'b010) dec.itype = rv_isa_pkg::STORE;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        dec.itype = rv_isa_pkg::BRANCH;
        dec.imm   = imm_b;
        case (funct3)
          3'b000: dec.br_op = rv_isa_pkg::EQ;
          3'b001: dec.br_op = rv_isa_pkg::NE;
          3'b100: dec.br_op = rv_isa_pkg::LT;
          3'b101: dec.br_op = rv_isa_pkg::GE;
          default: dec.itype = rv_isa_pkg::ILLEGAL;  // Unsigned branches dropped
        endcase
      end
      rv_isa_pkg::OPC_JAL: begin
        dec.itype = rv_isa_pkg::JAL;
        dec.imm   = imm_j;
      end
      default: dec.itype = rv_isa_pkg::ILLEGAL;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file (
  input  wire        clk_100mhz,
  input  wire        rst_in,
  input  wire [4:0]  rs1,
  input  wire [4:0]  rs2,
  input  wire [4:0]  wa,
  input  wire [31:0] wd,
  input  wire        we,
  output logic [31:0] rval1,
  output logic [31:0] rval2
);

  logic [31:0] regs [1:31];  // x0 has no storage

  // Combinational reads, x0 reads as zero
  assign rval1 = (rs1 == 5'd0) ? 32'h0 : regs[rs1];
  assign rval2 = (rs2 == 5'd0) ? 32'h0 : regs[rs2];

  always_ff @(posedge clk_100mhz) begin
    if (rst_in) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= 32'h0;
      end
    end else if (we && wa != 5'd0) begin
      regs[wa] <= wd;  // Writes to x0 dropped
    end
  end

endmodule

`default_nettype wire

// ==== rtl/execute_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
  input  wire rv_isa_pkg::decoded_t dec,
  input  wire [31:0]                pc,
  input  wire [31:0]                rval1,
  input  wire [31:0]                rval2,
  output core_pkg::exec_result_t    ex
);

  logic [31:0] op_b;
  logic [4:0]  shamt;
  logic [31:0] alu_out;
  logic [31:0] pc_plus4;
  logic        taken;

  assign op_b     = (dec.itype == rv_isa_pkg::OP) ? rval2 : dec.imm;  // Reg or imm operand
  assign shamt    = op_b[4:0];
  assign pc_plus4 = pc + 32'd4;

  // ALU
  always_comb begin
    case (dec.alu_op)
      rv_isa_pkg::ADD: alu_out = rval1 + op_b;
      rv_isa_pkg::SUB: alu_out = rval1 - op_b;
      rv_isa_pkg::AND: alu_out = rval1 & op_b;
      rv_isa_pkg::OR:  alu_out = rval1 | op_b;
      rv_isa_pkg::XOR: alu_out = rval1 ^ op_b;
      rv_isa_pkg::SLT: alu_out = {31'b0, $signed(rval1) < $signed(op_b)};
      rv_isa_pkg::SLL: alu_out = rval1 << shamt;
      rv_isa_pkg::SRL: alu_out = rval1 >> shamt;
      rv_isa_pkg::SRA: alu_out = $signed(rval1) >>> shamt;  // Keeps sign
      default:         alu_out = 32'h0;
    endcase
  end

  // Branch compare, signed
  always_comb begin
    case (dec.br_op)
      rv_isa_pkg::EQ: taken = (rval1 == rval2);
      rv_isa_pkg::NE: taken = (rval1 != rval2);
      rv_isa_pkg::LT: taken = ($signed(rval1) < $signed(rval2));
      rv_isa_pkg::GE: taken = ($signed(rval1) >= $signed(rval2));
      default:        taken = 1'b0;
    endcase
  end

  always_comb begin
    ex.result     = alu_out;
    ex.next_pc    = pc_plus4;
    ex.mem_addr   = rval1 + dec.imm;  // Byte address for LW/SW
    ex.store_data = rval2;
    case (dec.itype)
      rv_isa_pkg::LUI: ex.result = dec.imm;  // Upper immediate passes through
      rv_isa_pkg::JAL: begin
        ex.result  = pc_plus4;  // Link value
        ex.next_pc = pc + dec.imm;
      end
      rv_isa_pkg::BRANCH: begin
        if (taken) ex.next_pc = pc + dec.imm;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/mem_writeback.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_writeback (
  input  wire                          clk_100mhz,
  input  wire                          rst_in,
  input  wire core_pkg::core_state_e   state,
  input  wire [31:0]                   pc,
  input  wire rv_isa_pkg::decoded_t    dec,
  input  wire core_pkg::exec_result_t  ex,
  output logic [4:0]                   wa,
  output logic [31:0]                  wd,
  output logic                         we,
  output logic                         retire_valid,
  output core_pkg::retire_t            retire
);

  logic [31:0] dmem [0:core_pkg::DMEM_DEPTH-1];
  core_pkg::exec_result_t ex_q;             // Captured at end of EXECUTE
  logic [core_pkg::DMEM_AW-1:0] dmem_word;
  logic writes_rd;

  assign dmem_word = ex_q.mem_addr[core_pkg::DMEM_AW+1:2];  // Word index, low bits ignored

  // Classes that produce a register value, never x0
  assign writes_rd = (dec.itype inside {rv_isa_pkg::OP, rv_isa_pkg::OP_IMM,
                                        rv_isa_pkg::LUI, rv_isa_pkg::LOAD,
                                        rv_isa_pkg::JAL}) && (dec.rd != 5'd0);

  always_ff @(posedge clk_100mhz) begin
    if (state == core_pkg::EXECUTE) ex_q <= ex;
    if (state == core_pkg::MEMORY && dec.itype == rv_isa_pkg::STORE)
      dmem[dmem_word] <= ex_q.store_data;
  end

  // Trace register, loaded in MEMORY so it is valid during WRITEBACK
  always_ff @(posedge clk_100mhz) begin
    if (rst_in) begin
      retire_valid <= 1'b0;
      retire       <= '0;
    end else begin
      retire_valid <= (state == core_pkg::MEMORY);  // One cycle, lands in WRITEBACK
      if (state == core_pkg::MEMORY) begin
        retire.pc      <= pc;
        retire.next_pc <= ex_q.next_pc;
        retire.rd      <= dec.rd;
        // Loaded word or result, one-cycle memory read
        retire.wdata   <= (dec.itype == rv_isa_pkg::LOAD) ? dmem[dmem_word] : ex_q.result;
        retire.wen     <= writes_rd;
      end
    end
  end

  // Register write comes straight from the trace
  assign wa = retire.rd;
  assign wd = retire.wdata;
  assign we = (state == core_pkg::WRITEBACK) && retire.wen;

endmodule

`default_nettype wire

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core (
  input  wire                          clk_100mhz,
  input  wire                          rst_in,
  input  wire                          run,          // Level, executes while high
  input  wire                          prog_we,      // Program load, run low only
  input  wire [core_pkg::IMEM_AW-1:0]  prog_addr,
  input  wire [31:0]                   prog_data,
  output logic                         retire_valid,
  output core_pkg::retire_t            retire
);

  core_pkg::core_state_e  state;
  logic [31:0]            pc;
  logic [31:0]            inst;
  rv_isa_pkg::decoded_t   dec;
  logic [31:0]            rval1, rval2;
  core_pkg::exec_result_t ex;
  logic [4:0]             wa;
  logic [31:0]            wd;
  logic                   we;

  fetch_unit u_fetch (
    .clk_100mhz (clk_100mhz),
    .rst_in     (rst_in),
    .run        (run),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .next_pc    (ex.next_pc),  // Taken in WRITEBACK
    .state      (state),
    .pc         (pc),
    .inst       (inst)
  );

  decoder u_decoder (.inst(inst), .dec(dec));

  register_file u_regs (
    .clk_100mhz (clk_100mhz),
    .rst_in     (rst_in),
    .rs1        (dec.rs1),
    .rs2        (dec.rs2),
    .wa         (wa),
    .wd         (wd),
    .we         (we),
    .rval1      (rval1),
    .rval2      (rval2)
  );

  execute_unit u_execute (.dec(dec), .pc(pc), .rval1(rval1), .rval2(rval2), .ex(ex));

  mem_writeback u_mem_wb (
    .clk_100mhz   (clk_100mhz),
    .rst_in       (rst_in),
    .state        (state),
    .pc           (pc),
    .dec          (dec),
    .ex           (ex),
    .wa           (wa),
    .wd           (wd),
    .we           (we),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

`default_nettype wire

// ==== tb/clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
  output logic clk_100mhz,
  output logic rst_in
);

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;  // 10 ns period
  end

  initial begin
    rst_in = 1'b1;
    repeat (2) @(posedge clk_100mhz);  // Two cycles of reset
    rst_in <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb/core_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_checker (
  input  wire                clk_100mhz,
  input  wire                rst_in,
  input  wire                run,
  input  wire                retire_valid,
  input  wire core_pkg::retire_t retire,
  input  wire core_pkg::retire_t exp_rows [0:core_pkg::IMEM_DEPTH-1],
  input  var int             n_exp,
  output int                 errors,
  output int                 n_retired
);

  int gap;                   // Cycles since run first seen or last retire
  logic run_seen;
  int cycle_errs;            // Errors found at this edge
  core_pkg::retire_t want;

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp_val);
    if (got !== exp_val) begin
      $display("Mismatch %s: got %h, expected %h (retire %0d)", name, got, exp_val, n_retired);
      cycle_errs++;
    end
  endtask

  always @(posedge clk_100mhz) begin
    cycle_errs = 0;
    if (rst_in) begin
      errors    <= 0;
      n_retired <= 0;
      gap       <= 0;
      run_seen  <= 1'b0;
    end else begin
      if (run && !run_seen) begin
        run_seen <= 1'b1;
        gap      <= 1;         // First FETCH cycle
      end else begin
        gap <= gap + 1;
      end
      if (retire_valid) begin
        gap <= 1;
        if (!run_seen) begin
          $display("Retire seen before run was ever raised");
          cycle_errs++;
        end else if (gap != 5) begin
          $display("Retire came %0d cycles after the previous one, expected 5", gap);
          cycle_errs++;
        end
        if (n_retired >= n_exp) begin
          $display("Extra retire at pc %h after all %0d expected retires", retire.pc, n_exp);
          cycle_errs++;
        end else begin
          want = exp_rows[n_retired];
          compare_field("pc", retire.pc, want.pc);
          compare_field("next_pc", retire.next_pc, want.next_pc);
          compare_field("wen", 32'(retire.wen), 32'(want.wen));
          if (want.wen) begin  // rd and wdata only matter when written
            compare_field("rd", 32'(retire.rd), 32'(want.rd));
            compare_field("wdata", retire.wdata, want.wdata);
          end
        end
        n_retired <= n_retired + 1;
      end
      errors <= errors + cycle_errs;
    end
  end

endmodule

`default_nettype wire

// ==== tb/core_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_assert (
  input wire                        clk_100mhz,
  input wire                        rst_in,
  input wire core_pkg::core_state_e state,
  input wire                        we,
  input wire                        retire_valid,
  input wire core_pkg::retire_t     retire
);

  int fail_count = 0;  // Failed assertions so far

  // Retire is a single-cycle pulse
  retire_one_cycle: assert property (@(posedge clk_100mhz) disable iff (rst_in)
    retire_valid |=> !retire_valid)
    else begin
      $error("retire_valid stayed high for two cycles");
      fail_count++;
    end

  we_in_writeback: assert property (@(posedge clk_100mhz) disable iff (rst_in)
    we |-> state == core_pkg::WRITEBACK)
    else begin
      $error("Register write enable outside WRITEBACK");
      fail_count++;
    end

  // x0 is never reported as written
  no_x0_write: assert property (@(posedge clk_100mhz) disable iff (rst_in)
    retire_valid |-> !(retire.wen && retire.rd == 5'd0))
    else begin
      $error("Retire with rd x0 and wen high");
      fail_count++;
    end

  no_idle_retire: assert property (@(posedge clk_100mhz) disable iff (rst_in)
    retire_valid |-> state != core_pkg::IDLE)
    else begin
      $error("Retire while the sequencer is in IDLE");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== tb/tb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_top;

  logic clk_100mhz;
  logic rst_in;
  logic run;
  logic prog_we;
  logic [core_pkg::IMEM_AW-1:0] prog_addr;
  logic [31:0] prog_data;
  logic retire_valid;
  core_pkg::retire_t retire;

  logic [31:0] prog [0:core_pkg::IMEM_DEPTH-1];             // Program image
  core_pkg::retire_t exp_rows [0:core_pkg::IMEM_DEPTH-1];   // Expected retires, in order
  int n_prog;
  int n_exp;
  logic [31:0] xreg [0:31];           // Architectural registers as the ISA defines them
  logic [31:0] xmem [logic [31:0]];   // Stored words by byte address
  logic [31:0] lcg_state;
  int errors;
  int n_retired;
  int cycles;
  int limit;

  clock_gen u_clock_gen (.clk_100mhz(clk_100mhz), .rst_in(rst_in));

  rv_core UUT (
    .clk_100mhz   (clk_100mhz),
    .rst_in       (rst_in),
    .run          (run),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  core_checker u_checker (
    .clk_100mhz   (clk_100mhz),
    .rst_in       (rst_in),
    .run          (run),
    .retire_valid (retire_valid),
    .retire       (retire),
    .exp_rows     (exp_rows),
    .n_exp        (n_exp),
    .errors       (errors),
    .n_retired    (n_retired)
  );

  bind rv_core core_assert u_core_assert (
    .clk_100mhz(clk_100mhz), .rst_in(rst_in), .state(state),
    .we(we), .retire_valid(retire_valid), .retire(retire)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // RV32I result of one ALU funct3, alt is funct7 bit 5
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b111:  return a & b;
      3'b110:  return a | b;
      3'b100:  return a ^ b;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b001:  return a << b[4:0];
      3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] seq_pc();
    return 32'(n_prog * 4 + 4);  // Fall-through pc of the word being placed
  endfunction

  // Places one word that retires, and updates the register model
  task automatic emit(input logic [31:0] word, input logic [31:0] nxt, input logic [4:0] rd,
                      input logic [31:0] val, input logic wen);
    exp_rows[n_exp].pc      = 32'(n_prog * 4);
    exp_rows[n_exp].next_pc = nxt;
    exp_rows[n_exp].rd      = rd;
    exp_rows[n_exp].wdata   = val;
    exp_rows[n_exp].wen     = wen;
    n_exp++;
    prog[n_prog] = word;
    n_prog++;
    if (wen) xreg[rd] = val;
  endtask

  task automatic place_filler();
    prog[n_prog] = {12'd1, 5'd31, 3'b000, 5'd31, 7'b0010011};  // addi x31, x31, 1, jumped over
    n_prog++;
  endtask

  task automatic op_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] imm);
    emit({imm, rs1, f3, rd, 7'b0010011}, seq_pc(), rd,
         alu_ref(f3, 1'b0, xreg[rs1], {{20{imm[11]}}, imm}), rd != 5'd0);
  endtask

  task automatic op_reg(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
    emit({alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'b0110011}, seq_pc(), rd,
         alu_ref(f3, alt, xreg[rs1], xreg[rs2]), rd != 5'd0);
  endtask

  task automatic load_upper(input logic [4:0] rd, input logic [19:0] imm);
    emit({imm, rd, 7'b0110111}, seq_pc(), rd, {imm, 12'h000}, rd != 5'd0);
  endtask

  task automatic store_word(input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] imm);
    xmem[xreg[rs1] + {{20{imm[11]}}, imm}] = xreg[rs2];
    emit({imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}, seq_pc(), 5'd0, 32'h0, 1'b0);
  endtask

  task automatic load_word(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    emit({imm, rs1, 3'b010, rd, 7'b0000011}, seq_pc(), rd,
         xmem[xreg[rs1] + {{20{imm[11]}}, imm}], rd != 5'd0);
  endtask

  // Branch by +8, so a taken branch skips one filler word
  task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
    logic taken;
    case (f3)
      3'b000:  taken = xreg[rs1] == xreg[rs2];
      3'b001:  taken = xreg[rs1] != xreg[rs2];
      3'b100:  taken = $signed(xreg[rs1]) < $signed(xreg[rs2]);
      default: taken = $signed(xreg[rs1]) >= $signed(xreg[rs2]);
    endcase
    emit({7'b0, rs2, rs1, f3, 4'b0100, 1'b0, 7'b1100011},
         taken ? seq_pc() + 32'd4 : seq_pc(), 5'd0, 32'h0, 1'b0);
    if (taken) place_filler();
  endtask

  task automatic jump_link(input logic [4:0] rd);
    emit({1'b0, 10'd4, 1'b0, 8'd0, rd, 7'b1101111}, seq_pc() + 32'd4, rd, seq_pc(),
         rd != 5'd0);  // Offset +8, link is pc + 4
    place_filler();
  endtask

  task automatic build_table();
    logic [31:0] r;
    lcg_state = 32'h9752c237;
    n_prog = 0;
    n_exp  = 0;
    for (int i = 0; i < 32; i++) xreg[i] = 32'h0;
    r = lcg_next();
    op_imm(3'b000, 5'd1, 5'd0, r[27:16]);
    r = lcg_next();
    op_imm(3'b000, 5'd2, 5'd0, r[27:16]);
    r = lcg_next();
    load_upper(5'd3, {1'b1, r[30:12]});   // Negative, for SRA and SLT
    op_reg(3'b000, 1'b0, 5'd4, 5'd1, 5'd2);
    op_reg(3'b000, 1'b1, 5'd5, 5'd1, 5'd2);  // SUB
    op_reg(3'b111, 1'b0, 5'd6, 5'd1, 5'd3);
    op_reg(3'b110, 1'b0, 5'd7, 5'd1, 5'd3);
    op_reg(3'b100, 1'b0, 5'd8, 5'd2, 5'd3);
    op_imm(3'b000, 5'd11, 5'd0, 12'hffb);    // x11 = -5
    op_reg(3'b010, 1'b0, 5'd9, 5'd11, 5'd1);
    op_reg(3'b010, 1'b0, 5'd10, 5'd3, 5'd11);
    op_imm(3'b010, 5'd12, 5'd11, 12'hffd);   // -5 < -3
    r = lcg_next();
    op_imm(3'b111, 5'd13, 5'd3, r[27:16]);
    r = lcg_next();
    op_imm(3'b110, 5'd14, 5'd1, r[27:16]);
    r = lcg_next();
    op_imm(3'b100, 5'd15, 5'd2, r[27:16]);
    r = lcg_next();
    op_imm(3'b010, 5'd16, 5'd1, r[27:16]);
    op_reg(3'b001, 1'b0, 5'd17, 5'd3, 5'd2);
    op_reg(3'b101, 1'b0, 5'd18, 5'd3, 5'd2);
    op_reg(3'b101, 1'b1, 5'd19, 5'd3, 5'd2);  // SRA
    op_imm(3'b000, 5'd0, 5'd1, 12'd5);       // Write to x0 is dropped
    op_reg(3'b000, 1'b0, 5'd20, 5'd0, 5'd1);
    op_imm(3'b000, 5'd22, 5'd0, 12'h100);    // Data base address
    store_word(5'd4, 5'd22, 12'd8);
    load_word(5'd23, 5'd22, 12'd8);
    store_word(5'd5, 5'd22, 12'hffc);
    load_word(5'd24, 5'd22, 12'hffc);
    op_imm(3'b000, 5'd25, 5'd0, 12'd1);
    branch(3'b000, 5'd1, 5'd1);
    branch(3'b000, 5'd25, 5'd0);
    branch(3'b001, 5'd25, 5'd0);
    branch(3'b001, 5'd1, 5'd1);
    branch(3'b100, 5'd11, 5'd25);
    branch(3'b100, 5'd25, 5'd11);
    branch(3'b101, 5'd25, 5'd11);
    branch(3'b101, 5'd11, 5'd25);
    branch(3'b101, 5'd1, 5'd1);              // Equal operands take BGE
    jump_link(5'd26);
    jump_link(5'd0);
    op_imm(3'b000, 5'd27, 5'd26, 12'd4);     // Uses the link value
  endtask

  // Timeout
  always @(posedge clk_100mhz) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles, %0d of %0d retires seen", cycles, n_retired, n_exp);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = 32'h0;
    cycles    = 0;
    build_table();
    limit = n_prog + 5 * n_exp + 50;
    @(posedge clk_100mhz);
    while (rst_in) @(posedge clk_100mhz);
    for (int i = 0; i < n_prog; i++) begin  // One word per cycle, run low
      prog_we   <= 1'b1;
      prog_addr <= i[core_pkg::IMEM_AW-1:0];
      prog_data <= prog[i];
      @(posedge clk_100mhz);
    end
    prog_we <= 1'b0;
    @(posedge clk_100mhz);
    run <= 1'b1;
    // Drop run while the last instruction is in flight, it still completes
    while (n_retired < n_exp - 1) @(posedge clk_100mhz);
    run <= 1'b0;
    while (n_retired < n_exp) @(posedge clk_100mhz);
    repeat (10) @(posedge clk_100mhz);  // Room for any stray retire
    $display("Closing: %0d of %0d retires checked, %0d errors, %0d assertion failures",
             n_retired, n_exp, errors, UUT.u_core_assert.fail_count);
    if (errors == 0 && UUT.u_core_assert.fail_count == 0 && n_retired == n_exp) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/rv_isa_pkg.sv
rtl/core_pkg.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/register_file.sv
rtl/execute_unit.sv
rtl/mem_writeback.sv
rtl/rv_core.sv
tb/clock_gen.sv
tb/core_checker.sv
tb/core_assert.sv
tb/tb_top.sv

// ==== Makefile ====
# Verilator build and run for the RV32I subset core

VERILATOR ?= verilator
TOP       ?= tb_top
BUILD_DIR ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Regression passed

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Status is that of the search for the pass line
run: $(SIM)
	@out="$$($(SIM) $(SIM_ARGS))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
